//--- Bender.yml
package:
  name: rsa_wb_top

sources:
  - rsa_pkg.sv
  - rsa_prep.sv
  - rsa_mont.sv
  - rsa_core.sv
  - rsa_wb_regs.sv
  - rsa_wb_top.sv
  - target: test
    files:
      - tb_rsa_clk.sv
      - tb_rsa.sv

//--- rsa_core.sv
`timescale 1ns/1ps

module rsa_core (
	input  logic          i_clk,
	input  logic          i_rst,
	input  logic          i_start,
	input  rsa_pkg::key_t i_a,
	input  rsa_pkg::key_t i_d,
	input  rsa_pkg::key_t i_n,
	output rsa_pkg::key_t o_result,
	output logic          o_busy,
	output logic          o_done
);

	rsa_pkg::core_state_e state;
	rsa_pkg::key_t        a_r;
	rsa_pkg::key_t        d_r;
	rsa_pkg::key_t        n_r;
	rsa_pkg::key_t        t_r;
	rsa_pkg::key_t        res_r;
	rsa_pkg::key_t        prep_m;
	rsa_pkg::key_t        mul_m;
	rsa_pkg::key_t        sqr_m;
	rsa_pkg::cnt_t        cnt;
	logic                 prep_start;
	logic                 prep_done;
	logic                 mul_start;
	logic                 mul_done;
	logic                 sqr_start;
	logic                 sqr_done;
	logic                 mul_seen;
	logic                 sqr_seen;
	logic                 bit_set;

	assign bit_set  = d_r[cnt[7:0]];
	assign o_result = res_r;
	assign o_busy   = (state != rsa_pkg::S_IDLE);

	// base into the Montgomery domain
	rsa_prep u_prep (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (prep_start),
		.i_n     (n_r),
		.i_b     (a_r),
		.o_m     (prep_m),
		.o_done  (prep_done)
	);

	// result times running power, plain result keeps the domain neutral
	rsa_mont u_mul (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (mul_start),
		.i_n     (n_r),
		.i_a     (res_r),
		.i_b     (t_r),
		.o_m     (mul_m),
		.o_done  (mul_done)
	);

	rsa_mont u_sqr (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (sqr_start),
		.i_n     (n_r),
		.i_a     (t_r),
		.i_b     (t_r),
		.o_m     (sqr_m),
		.o_done  (sqr_done)
	);

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state      <= rsa_pkg::S_IDLE;
			cnt        <= '0;
			res_r      <= rsa_pkg::key_t'(1);
			prep_start <= 1'b0;
			mul_start  <= 1'b0;
			sqr_start  <= 1'b0;
			mul_seen   <= 1'b0;
			sqr_seen   <= 1'b0;
			o_done     <= 1'b0;
		end else begin
			prep_start <= 1'b0;
			mul_start  <= 1'b0;
			sqr_start  <= 1'b0;
			o_done     <= 1'b0;
			case (state)
				rsa_pkg::S_IDLE: begin
					if (i_start) begin
						cnt        <= '0;
						res_r      <= rsa_pkg::key_t'(1);
						prep_start <= 1'b1;
						state      <= rsa_pkg::S_PREP;
					end
				end
				rsa_pkg::S_PREP: begin
					if (prep_done) begin
						state <= rsa_pkg::S_STEP;
					end
				end
				rsa_pkg::S_STEP: begin
					sqr_start <= 1'b1;
					mul_start <= bit_set;
					// a zero bit needs no multiply, count it as seen
					mul_seen  <= ~bit_set;
					sqr_seen  <= 1'b0;
					state     <= rsa_pkg::S_WAIT;
				end
				rsa_pkg::S_WAIT: begin
					if (mul_done) begin
						mul_seen <= 1'b1;
					end
					if (sqr_done) begin
						sqr_seen <= 1'b1;
					end
					if (mul_seen && sqr_seen) begin
						if (bit_set) begin
							res_r <= mul_m;
						end
						cnt   <= cnt + 1'b1;
						state <= rsa_pkg::S_NEXT;
					end
				end
				rsa_pkg::S_NEXT: begin
					if (cnt == rsa_pkg::cnt_t'(rsa_pkg::KEY_W)) begin
						o_done <= 1'b1;
						state  <= rsa_pkg::S_IDLE;
					end else begin
						state <= rsa_pkg::S_STEP;
					end
				end
				default: state <= rsa_pkg::S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == rsa_pkg::S_IDLE && i_start) begin
			a_r <= i_a;
			d_r <= i_d;
			n_r <= i_n;
		end
		if (state == rsa_pkg::S_PREP && prep_done) begin
			t_r <= prep_m;
		end else if (state == rsa_pkg::S_WAIT && mul_seen && sqr_seen) begin
			t_r <= sqr_m;
		end
	end

endmodule

//--- rsa_mont.sv
`timescale 1ns/1ps

module rsa_mont (
	input  logic          i_clk,
	input  logic          i_rst,
	input  logic          i_start,
	input  rsa_pkg::key_t i_n,
	input  rsa_pkg::key_t i_a,
	input  rsa_pkg::key_t i_b,
	output rsa_pkg::key_t o_m,
	output logic          o_done
);

	rsa_pkg::ext_t acc;
	rsa_pkg::ext_t b_ext;
	rsa_pkg::ext_t n_ext;
	rsa_pkg::ext_t s1;
	rsa_pkg::ext_t s2;
	rsa_pkg::ext_t sub;
	rsa_pkg::cnt_t cnt;
	logic          run;
	logic          fin;

	assign b_ext = {2'b00, i_b};
	assign n_ext = {2'b00, i_n};

	// add b when the scanned bit of a is set
	assign s1 = i_a[cnt[7:0]] ? acc + b_ext : acc;
	// make the sum even so the halving is exact
	assign s2 = s1[0] ? s1 + n_ext : s1;
	assign sub = acc - n_ext;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			cnt    <= '0;
			run    <= 1'b0;
			fin    <= 1'b0;
			o_done <= 1'b0;
		end else begin
			o_done <= fin;
			fin    <= 1'b0;
			if (i_start) begin
				cnt <= '0;
				run <= 1'b1;
			end else if (run) begin
				cnt <= cnt + 1'b1;
				if (cnt == rsa_pkg::cnt_t'(rsa_pkg::KEY_W - 1)) begin
					run <= 1'b0;
					fin <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start) begin
			acc <= '0;
		end else if (run) begin
			acc <= {1'b0, s2[rsa_pkg::KEY_W+1:1]};
		end
		// acc stays below 2n, one subtract is enough
		if (fin) begin
			o_m <= (acc >= n_ext) ? sub[rsa_pkg::KEY_W-1:0] : acc[rsa_pkg::KEY_W-1:0];
		end
	end

endmodule

//--- rsa_pkg.sv
package rsa_pkg;

	// operand width, fixed by the register map
	localparam int KEY_W = 256;

	typedef logic [KEY_W-1:0] key_t;
	// two spare bits for sums that can reach 4n
	typedef logic [KEY_W+1:0] ext_t;
	// counts 0 to 256
	typedef logic [8:0]       cnt_t;

	typedef logic [31:0]      wb_data_t;
	typedef logic [6:0]       wb_addr_t;

	// word offsets, eight words per operand, ls word first
	localparam wb_addr_t ADDR_A_BASE = 7'd0;
	localparam wb_addr_t ADDR_D_BASE = 7'd8;
	localparam wb_addr_t ADDR_N_BASE = 7'd16;
	localparam wb_addr_t ADDR_R_BASE = 7'd24;
	localparam wb_addr_t ADDR_CTRL   = 7'd32;
	localparam wb_addr_t ADDR_STAT   = 7'd33;

	typedef enum logic [2:0] {
		S_IDLE,
		S_PREP,
		S_STEP,
		S_WAIT,
		S_NEXT
	} core_state_e;

endpackage

//--- rsa_prep.sv
`timescale 1ns/1ps

module rsa_prep (
	input  logic          i_clk,
	input  logic          i_rst,
	input  logic          i_start,
	input  rsa_pkg::key_t i_n,
	input  rsa_pkg::key_t i_b,
	output rsa_pkg::key_t o_m,
	output logic          o_done
);

	rsa_pkg::ext_t acc;
	rsa_pkg::ext_t n_ext;
	rsa_pkg::ext_t val;
	rsa_pkg::ext_t red;
	rsa_pkg::cnt_t cnt;
	logic          run;
	logic          fin;

	assign n_ext = {2'b00, i_n};
	// round 0 only reduces b, the other 256 rounds double first
	assign val = (cnt == '0) ? acc : {acc[rsa_pkg::KEY_W:0], 1'b0};
	assign red = (val >= n_ext) ? val - n_ext : val;
	assign o_m = acc[rsa_pkg::KEY_W-1:0];

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			cnt    <= '0;
			run    <= 1'b0;
			fin    <= 1'b0;
			o_done <= 1'b0;
		end else begin
			o_done <= fin;
			fin    <= 1'b0;
			if (i_start) begin
				cnt <= '0;
				run <= 1'b1;
			end else if (run) begin
				cnt <= cnt + 1'b1;
				// round 256 is the last of 257
				if (cnt == rsa_pkg::cnt_t'(rsa_pkg::KEY_W)) begin
					run <= 1'b0;
					fin <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start) begin
			acc <= {2'b00, i_b};
		end else if (run) begin
			acc <= red;
		end
	end

endmodule

//--- rsa_wb_regs.sv
`timescale 1ns/1ps

module rsa_wb_regs (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_wb_cyc,
	input  logic              i_wb_stb,
	input  logic              i_wb_we,
	input  rsa_pkg::wb_addr_t i_wb_adr,
	input  rsa_pkg::wb_data_t i_wb_dat,
	input  logic [3:0]        i_wb_sel,
	output rsa_pkg::wb_data_t o_wb_dat,
	output logic              o_wb_ack,
	output logic              o_start,
	output rsa_pkg::key_t     o_a,
	output rsa_pkg::key_t     o_d,
	output rsa_pkg::key_t     o_n,
	input  rsa_pkg::key_t     i_result,
	input  logic              i_busy,
	input  logic              i_done
);

	rsa_pkg::key_t     a_r;
	rsa_pkg::key_t     d_r;
	rsa_pkg::key_t     n_r;
	rsa_pkg::wb_data_t rd_mux;
	logic [7:0]        word_base;
	logic              req;
	logic              wr;
	logic              busy_q;
	logic              op_wr;
	logic              start_req;
	logic              sel_a;
	logic              sel_d;
	logic              sel_n;
	logic              sel_r;
	logic              done_r;

	// one ack per transfer, master holds stb until it sees ack
	assign req = i_wb_cyc & i_wb_stb & ~o_wb_ack;
	assign wr  = req & i_wb_we;

	// start pulse still in flight counts as busy
	assign busy_q = i_busy | o_start;

	assign word_base = {i_wb_adr[2:0], 5'b00000};
	assign sel_a = (i_wb_adr[6:3] == rsa_pkg::ADDR_A_BASE[6:3]);
	assign sel_d = (i_wb_adr[6:3] == rsa_pkg::ADDR_D_BASE[6:3]);
	assign sel_n = (i_wb_adr[6:3] == rsa_pkg::ADDR_N_BASE[6:3]);
	assign sel_r = (i_wb_adr[6:3] == rsa_pkg::ADDR_R_BASE[6:3]);

	assign op_wr     = wr & ~busy_q;
	assign start_req = wr & (i_wb_adr == rsa_pkg::ADDR_CTRL) & i_wb_dat[0] & ~busy_q;

	assign o_a = a_r;
	assign o_d = d_r;
	assign o_n = n_r;

	always_comb begin
		rd_mux = '0;
		if (sel_a) begin
			rd_mux = a_r[word_base +: 32];
		end else if (sel_d) begin
			rd_mux = d_r[word_base +: 32];
		end else if (sel_n) begin
			rd_mux = n_r[word_base +: 32];
		end else if (sel_r) begin
			rd_mux = i_result[word_base +: 32];
		end else if (i_wb_adr == rsa_pkg::ADDR_STAT) begin
			rd_mux = {30'd0, done_r, i_busy};
		end
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_wb_ack <= 1'b0;
			o_start  <= 1'b0;
			done_r   <= 1'b0;
		end else begin
			o_wb_ack <= req;
			o_start  <= start_req;
			if (start_req) begin
				done_r <= 1'b0;
			end else if (i_done) begin
				done_r <= 1'b1;
			end
		end
	end

	// operand words with byte enables
	always_ff @(posedge i_clk) begin
		if (op_wr) begin
			for (int i = 0; i < 4; i++) begin
				if (i_wb_sel[i]) begin
					if (sel_a) begin
						a_r[word_base + i*8 +: 8] <= i_wb_dat[i*8 +: 8];
					end else if (sel_d) begin
						d_r[word_base + i*8 +: 8] <= i_wb_dat[i*8 +: 8];
					end else if (sel_n) begin
						n_r[word_base + i*8 +: 8] <= i_wb_dat[i*8 +: 8];
					end
				end
			end
		end
		if (req && !i_wb_we) begin
			o_wb_dat <= rd_mux;
		end
	end

endmodule

//--- rsa_wb_top.f
rsa_pkg.sv
rsa_prep.sv
rsa_mont.sv
rsa_core.sv
rsa_wb_regs.sv
rsa_wb_top.sv
tb_rsa_clk.sv
tb_rsa.sv

//--- rsa_wb_top.sv
`timescale 1ns/1ps

module rsa_wb_top (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_wb_cyc,
	input  logic              i_wb_stb,
	input  logic              i_wb_we,
	input  rsa_pkg::wb_addr_t i_wb_adr,
	input  rsa_pkg::wb_data_t i_wb_dat,
	input  logic [3:0]        i_wb_sel,
	output rsa_pkg::wb_data_t o_wb_dat,
	output logic              o_wb_ack
);

	rsa_pkg::key_t a;
	rsa_pkg::key_t d;
	rsa_pkg::key_t n;
	rsa_pkg::key_t result;
	logic          start;
	logic          busy;
	logic          done;

	rsa_wb_regs u_regs (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_wb_cyc (i_wb_cyc),
		.i_wb_stb (i_wb_stb),
		.i_wb_we  (i_wb_we),
		.i_wb_adr (i_wb_adr),
		.i_wb_dat (i_wb_dat),
		.i_wb_sel (i_wb_sel),
		.o_wb_dat (o_wb_dat),
		.o_wb_ack (o_wb_ack),
		.o_start  (start),
		.o_a      (a),
		.o_d      (d),
		.o_n      (n),
		.i_result (result),
		.i_busy   (busy),
		.i_done   (done)
	);

	rsa_core u_core (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (start),
		.i_a      (a),
		.i_d      (d),
		.i_n      (n),
		.o_result (result),
		.o_busy   (busy),
		.o_done   (done)
	);

endmodule

//--- tb_rsa.sv
`timescale 1ns/1ps

module tb_rsa;

	localparam int N_VEC       = 6;
	localparam int CYCLE_LIMIT = N_VEC * 80000;

	logic         clk;
	logic         rst;
	logic         cyc;
	logic         stb;
	logic         we;
	logic [6:0]   adr;
	logic [31:0]  dat_w;
	logic [3:0]   sel;
	logic [31:0]  dat_r;
	logic         ack;
	logic [255:0] a_tab [N_VEC];
	logic [255:0] d_tab [N_VEC];
	logic [255:0] n_tab [N_VEC];
	logic [255:0] exp_tab [N_VEC];
	integer       seed      = 32'h5144;
	int           err_cnt   = 0;
	int           pass_cnt  = 0;
	int           fail_cnt  = 0;
	int           cycle_cnt = 0;

	tb_rsa_clk u_clk (.o_clk(clk));

	rsa_wb_top i_dut (
		.i_clk    (clk),
		.i_rst    (rst),
		.i_wb_cyc (cyc),
		.i_wb_stb (stb),
		.i_wb_we  (we),
		.i_wb_adr (adr),
		.i_wb_dat (dat_w),
		.i_wb_sel (sel),
		.o_wb_dat (dat_r),
		.o_wb_ack (ack)
	);

	// watchdog over the whole run
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// plain square and multiply with wide intermediates
	function automatic logic [255:0] ref_modexp(input logic [255:0] a, input logic [255:0] d,
		input logic [255:0] n);
		logic [511:0] r;
		logic [511:0] b;
		logic [511:0] m;
		m = {256'd0, n};
		r = 512'd1 % m;
		b = {256'd0, a} % m;
		for (int i = 0; i < 256; i++) begin
			if (d[i]) begin
				r = (r * b) % m;
			end
			b = (b * b) % m;
		end
		return r[255:0];
	endfunction

	function automatic logic [31:0] word_pattern(input logic [6:0] addr);
		return {addr, 1'b1, ~addr, 1'b0, addr ^ 7'h55, 2'b10, ~addr ^ 7'h2a};
	endfunction

	task automatic check_val(input logic [255:0] got, input logic [255:0] exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			$display("test %s: pass", name);
			pass_cnt++;
		end else begin
			$display("test %s: FAIL with %0d errors", name, err_cnt - errs_before);
			fail_cnt++;
		end
	endtask

	// one classic cycle with inputs moved 1 ns after the edge
	task automatic bus_transfer(input logic wr, input logic [6:0] addr, input logic [31:0] wdata,
		input logic [3:0] be, output logic [31:0] rdata);
		int waits;
		@(posedge clk);
		#1;
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = wr;
		adr   = addr;
		dat_w = wdata;
		sel   = be;
		waits = 0;
		// no ack before the first edge, nor left over from the last access
		#1;
		check_val(ack, 1'b0, $sformatf("ack before first edge at word %0d", addr));
		do begin
			@(posedge clk);
			#1;
			waits++;
		end while (!ack && waits < 8);
		rdata = dat_r;
		if (!ack) begin
			$display("bus access to word %0d at %0t ns was never acknowledged", addr, $time);
			err_cnt++;
		end else begin
			check_val(waits, 1, $sformatf("ack delay at word %0d", addr));
		end
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
	endtask

	task automatic wb_write(input logic [6:0] addr, input logic [31:0] data, input logic [3:0] be);
		logic [31:0] unused;
		bus_transfer(1'b1, addr, data, be, unused);
	endtask

	task automatic wb_read(input logic [6:0] addr, output logic [31:0] data);
		bus_transfer(1'b0, addr, 32'd0, 4'hf, data);
	endtask

	task automatic write_key(input logic [6:0] base, input logic [255:0] value);
		for (int k = 0; k < 8; k++) begin
			wb_write(base + 7'(k), value[k*32 +: 32], 4'hf);
		end
	endtask

	task automatic read_key(input logic [6:0] base, output logic [255:0] value);
		logic [31:0] word;
		for (int k = 0; k < 8; k++) begin
			wb_read(base + 7'(k), word);
			value[k*32 +: 32] = word;
		end
	endtask

	task automatic rand_key(output logic [255:0] v);
		for (int k = 0; k < 8; k++) begin
			v[k*32 +: 32] = $random(seed);
		end
	endtask

	// poll status until done and flag busy and done set together
	task automatic wait_done();
		logic [31:0] stat;
		stat = '0;
		while (!stat[1]) begin
			wb_read(rsa_pkg::ADDR_STAT, stat);
			if (stat[1] && stat[0]) begin
				$display("status shows busy and done at once at %0t ns", $time);
				err_cnt++;
			end
		end
	endtask

	task automatic build_table();
		for (int i = 0; i < N_VEC; i++) begin
			rand_key(n_tab[i]);
			n_tab[i][255] = 1'b1;
			n_tab[i][0]   = 1'b1;
			rand_key(a_tab[i]);
			a_tab[i] = a_tab[i] % n_tab[i];
			rand_key(d_tab[i]);
			exp_tab[i] = ref_modexp(a_tab[i], d_tab[i], n_tab[i]);
		end
		// hand values with known answers
		a_tab[0]   = 256'd4;
		d_tab[0]   = 256'd13;
		n_tab[0]   = 256'd497;
		exp_tab[0] = 256'd445;
		d_tab[1]   = 256'd0;
		exp_tab[1] = 256'd1;
		// base above n, so the answer is a mod n
		a_tab[2]   = 256'd1500;
		d_tab[2]   = 256'd1;
		n_tab[2]   = 256'd1009;
		exp_tab[2] = 256'd491;
		a_tab[3]   = 256'd0;
		d_tab[3][0] = 1'b1;
		exp_tab[3] = 256'd0;
	endtask

	task automatic test_reset();
		int           errs;
		logic [31:0]  stat;
		logic [255:0] res;
		errs = err_cnt;
		wb_read(rsa_pkg::ADDR_STAT, stat);
		check_val(stat, 32'd0, "status after reset");
		read_key(rsa_pkg::ADDR_R_BASE, res);
		check_val(res, 256'd1, "result after reset");
		report_test("reset values", errs);
	endtask

	task automatic test_unmapped();
		int          errs;
		logic [31:0] word;
		logic [6:0]  holes [5];
		errs = err_cnt;
		holes = '{7'd34, 7'd40, 7'd63, 7'd100, 7'd127};
		wb_write(7'd50, 32'hdeadbeef, 4'hf);
		wb_read(7'd50, word);
		check_val(word, 32'd0, "unmapped word 50 after write");
		foreach (holes[k]) begin
			wb_read(holes[k], word);
			check_val(word, 32'd0, $sformatf("unmapped word %0d", holes[k]));
		end
		report_test("unmapped reads", errs);
	endtask

	task automatic test_readback();
		int          errs;
		logic [31:0] word;
		errs = err_cnt;
		for (int k = 0; k < 24; k++) begin
			wb_write(7'(k), word_pattern(7'(k)), 4'hf);
		end
		for (int k = 0; k < 24; k++) begin
			wb_read(7'(k), word);
			check_val(word, word_pattern(7'(k)), $sformatf("operand word %0d", k));
		end
		// byte lanes 0 and 2, then lane 3 alone
		wb_write(rsa_pkg::ADDR_D_BASE + 7'd2, 32'h11223344, 4'hf);
		wb_write(rsa_pkg::ADDR_D_BASE + 7'd2, 32'haabbccdd, 4'b0101);
		wb_read(rsa_pkg::ADDR_D_BASE + 7'd2, word);
		check_val(word, 32'h11bb33dd, "byte select lanes 0 and 2");
		wb_write(rsa_pkg::ADDR_D_BASE + 7'd2, 32'h99000000, 4'b1000);
		wb_read(rsa_pkg::ADDR_D_BASE + 7'd2, word);
		check_val(word, 32'h99bb33dd, "byte select lane 3");
		report_test("operand readback", errs);
	endtask

	task automatic run_vector(input int idx);
		int           errs;
		logic [31:0]  stat;
		logic [31:0]  word;
		logic [255:0] res;
		errs = err_cnt;
		write_key(rsa_pkg::ADDR_A_BASE, a_tab[idx]);
		write_key(rsa_pkg::ADDR_D_BASE, d_tab[idx]);
		write_key(rsa_pkg::ADDR_N_BASE, n_tab[idx]);
		wb_write(rsa_pkg::ADDR_CTRL, 32'h1, 4'hf);
		// start sets busy and clears the old done
		wb_read(rsa_pkg::ADDR_STAT, stat);
		check_val(stat, 32'h1, "status right after start");
		wb_write(rsa_pkg::ADDR_A_BASE, ~a_tab[idx][31:0], 4'hf);
		wb_write(rsa_pkg::ADDR_CTRL, 32'h1, 4'hf);
		wb_read(rsa_pkg::ADDR_STAT, stat);
		check_val(stat, 32'h1, "status after start while busy");
		wait_done();
		read_key(rsa_pkg::ADDR_R_BASE, res);
		check_val(res, exp_tab[idx], $sformatf("vector %0d result", idx));
		wb_read(rsa_pkg::ADDR_STAT, stat);
		check_val(stat, 32'h2, "done bit held after completion");
		wb_read(rsa_pkg::ADDR_A_BASE, word);
		check_val(word, a_tab[idx][31:0], "operand write while busy");
		report_test($sformatf("vector %0d", idx), errs);
	endtask

	initial begin
		rst   = 1'b1;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = '0;
		dat_w = '0;
		sel   = '0;
		#1 rst = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst = 1'b1;
		build_table();
		test_reset();
		test_unmapped();
		test_readback();
		for (int i = 0; i < N_VEC; i++) begin
			run_vector(i);
		end
		$display("summary: %0d tests passed, %0d tests failed, %0d errors",
			pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0 && fail_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- tb_rsa_clk.sv
`timescale 1ns/1ps

module tb_rsa_clk (
	output logic o_clk
);

	// 4 ns period
	initial begin
		o_clk = 1'b0;
		forever begin
			#2 o_clk = ~o_clk;
		end
	end

endmodule
